/* Bender.yml */
package:
  name: primary_ray_gen

export_include_dirs:
  - src

sources:
  - target: rtl
    include_dirs:
      - src
    files:
      - src/prg_pkg.sv
      - src/pipe_stage.sv
      - src/scan_timer.sv
      - src/prg_fsm.sv
      - src/ray_dir_calc.sv
      - src/prg_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - verif/prg_checker.sv
      - verif/prg_tb.sv

/* src/pipe_stage.sv */
`timescale 1ns/10ps

module pipe_stage #(
	parameter type payload_t = logic,
	parameter int  depth     = 1
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	logic [depth-1:0] valid_q;
	payload_t         data_q [depth];

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < depth; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	// a stage only loads when a token moves into it, so data holds between tokens
	always_ff @(posedge clk) begin
		if (in_valid) begin
			data_q[0] <= in_data;
		end
		for (int i = 1; i < depth; i++) begin
			if (valid_q[i-1]) begin
				data_q[i] <= data_q[i-1];
			end
		end
	end

	assign out_valid = valid_q[depth-1];
	assign out_data  = data_q[depth-1];

endmodule

/* src/prg_config.svh */
`ifndef PRG_CONFIG_SVH
`define PRG_CONFIG_SVH

// default screen size, overridden per instance through parameters
`define PRG_SCREEN_W 640
`define PRG_SCREEN_H 480

// Q16.16 fixed point
`define PRG_FRAC_BITS 16

// focal distance D = 4.0
`define PRG_FOCAL_D 32'sh0004_0000

// pixel tag field widths, id covers 640 x 480
`define PRG_X_W  10
`define PRG_Y_W  9
`define PRG_ID_W 19

`endif

/* src/prg_fsm.sv */
`timescale 1ns/10ps

module prg_fsm (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic last_pixel,
	input  logic ph2,
	input  logic out_valid,
	output logic scan_en,
	output logic idle,
	output logic done
);

	typedef enum logic [1:0] {
		IDLE,
		RUN,
		DRAIN
	} state_t;

	state_t state;
	logic   drain_first;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			state       <= IDLE;
			drain_first <= 1'b0;
			done        <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				IDLE: begin
					// start while busy never reaches here
					if (start) begin
						state <= RUN;
					end
				end
				RUN: begin
					if (ph2 && last_pixel) begin
						state       <= DRAIN;
						drain_first <= 1'b1;
					end
				end
				DRAIN: begin
					drain_first <= 1'b0;
					// the ray leaving on the first drain cycle is the one before last
					if (out_valid && !drain_first) begin
						state <= IDLE;
						done  <= 1'b1;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	assign scan_en = (state == RUN);
	assign idle    = (state == IDLE);

endmodule

/* src/prg_pkg.sv */
`include "prg_config.svh"

package prg_pkg;

	// signed Q16.16 scalar
	typedef logic signed [31:0] fix_t;

	typedef struct packed {
		fix_t x;
		fix_t y;
		fix_t z;
	} vector_t;

	// eye position, the three screen axes and the pixel width
	typedef struct packed {
		vector_t eye;
		vector_t u_axis;
		vector_t v_axis;
		vector_t w_axis;
		fix_t    pw;
	} camera_t;

	// raster position plus running pixel id
	typedef struct packed {
		logic [`PRG_X_W-1:0]  x;
		logic [`PRG_Y_W-1:0]  y;
		logic [`PRG_ID_W-1:0] id;
	} pixel_t;

	// primary ray as handed to traversal
	typedef struct packed {
		logic [`PRG_ID_W-1:0] pixel_id;
		vector_t              origin;
		vector_t              dir;
	} prg_ray_t;

endpackage

/* src/prg_top.sv */
`timescale 1ns/10ps
`include "prg_config.svh"

module prg_top #(
	parameter int screen_w = `PRG_SCREEN_W,
	parameter int screen_h = `PRG_SCREEN_H
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  prg_pkg::camera_t  cam,
	output logic              idle,
	output logic              ray_valid,
	output prg_pkg::prg_ray_t ray,
	output logic              done
);

	logic              scan_en;
	logic              ph0;
	logic              ph1;
	logic              ph2;
	logic              last_pixel;
	logic              cam_load;
	logic              dir_valid;
	prg_pkg::pixel_t   pixel;
	prg_pkg::pixel_t   tag;
	prg_pkg::vector_t  dir;
	prg_pkg::vector_t  eye;
	prg_pkg::prg_ray_t ray_in;

	// camera only taken when the start is accepted
	assign cam_load = start && idle;

	scan_timer #(.screen_w(screen_w), .screen_h(screen_h)) u_timer (
		.clk, .rst, .scan_en, .ph0, .ph1, .ph2, .pixel, .last_pixel
	);

	prg_fsm u_fsm (
		.clk, .rst, .start, .last_pixel, .ph2, .out_valid(ray_valid),
		.scan_en, .idle, .done
	);

	ray_dir_calc #(.screen_w(screen_w), .screen_h(screen_h)) u_calc (
		.clk, .rst, .load(cam_load), .cam, .ph0, .ph1, .ph2, .pixel,
		.dir_valid, .dir, .eye
	);

	// tag enters at the end of its slot and holds until the direction is ready
	pipe_stage #(.payload_t(prg_pkg::pixel_t), .depth(2)) u_tag_pipe (
		.clk, .rst, .in_valid(ph2), .in_data(pixel), .out_valid(), .out_data(tag)
	);

	assign ray_in.pixel_id = tag.id;
	assign ray_in.origin   = eye;
	assign ray_in.dir      = dir;

	pipe_stage #(.payload_t(prg_pkg::prg_ray_t), .depth(1)) u_out_pipe (
		.clk, .rst, .in_valid(dir_valid), .in_data(ray_in),
		.out_valid(ray_valid), .out_data(ray)
	);

endmodule

/* src/ray_dir_calc.sv */
`timescale 1ns/10ps
`include "prg_config.svh"

module ray_dir_calc #(
	parameter int screen_w = `PRG_SCREEN_W,
	parameter int screen_h = `PRG_SCREEN_H
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             load,
	input  prg_pkg::camera_t cam,
	input  logic             ph0,
	input  logic             ph1,
	input  logic             ph2,
	input  prg_pkg::pixel_t  pixel,
	output logic             dir_valid,
	output prg_pkg::vector_t dir,
	output prg_pkg::vector_t eye
);

	// Q16.16 multiply, full product then arithmetic shift back
	function automatic prg_pkg::fix_t fmul(input prg_pkg::fix_t a, input prg_pkg::fix_t b);
		logic signed [63:0] prod;
		prod = a * b;
		return prg_pkg::fix_t'(prod >>> `PRG_FRAC_BITS);
	endfunction

	prg_pkg::camera_t cam_q;
	prg_pkg::vector_t dw_q;
	prg_pkg::vector_t dir_q;

	prg_pkg::fix_t coord_off;
	prg_pkg::fix_t uv_val;
	prg_pkg::fix_t u_q;
	prg_pkg::fix_t v_q;
	prg_pkg::fix_t u_hold;
	prg_pkg::fix_t v_hold;

	prg_pkg::fix_t mac_u;
	prg_pkg::fix_t mac_v;
	prg_pkg::fix_t mac_a;
	prg_pkg::fix_t mac_b;
	prg_pkg::fix_t mac_c;
	prg_pkg::fix_t mac_out;

	logic y_step;
	logic z_step;

	// u on ph0 and v on ph1 share one offset and multiply
	always_comb begin
		if (ph0) begin
			coord_off = (prg_pkg::fix_t'(pixel.x) - prg_pkg::fix_t'(screen_w / 2))
				<<< `PRG_FRAC_BITS;
		end else begin
			coord_off = (prg_pkg::fix_t'(pixel.y) - prg_pkg::fix_t'(screen_h / 2))
				<<< `PRG_FRAC_BITS;
		end
	end

	assign uv_val = fmul(coord_off, cam_q.pw);

	// x on ph2 straight from u_q and v_q, y and z later from the held copies
	always_comb begin
		mac_u = ph2 ? u_q : u_hold;
		mac_v = ph2 ? v_q : v_hold;
		if (ph2) begin
			mac_a = cam_q.u_axis.x;
			mac_b = cam_q.v_axis.x;
			mac_c = dw_q.x;
		end else if (y_step) begin
			mac_a = cam_q.u_axis.y;
			mac_b = cam_q.v_axis.y;
			mac_c = dw_q.y;
		end else begin
			mac_a = cam_q.u_axis.z;
			mac_b = cam_q.v_axis.z;
			mac_c = dw_q.z;
		end
		mac_out = fmul(mac_u, mac_a) + fmul(mac_v, mac_b) + mac_c;
	end

	// y and z steps run on after ph2, so the last pixel finishes after scanning stops
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			y_step    <= 1'b0;
			z_step    <= 1'b0;
			dir_valid <= 1'b0;
		end else begin
			y_step    <= ph2;
			z_step    <= y_step;
			dir_valid <= z_step;
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			cam_q  <= cam;
			dw_q.x <= fmul(`PRG_FOCAL_D, cam.w_axis.x);
			dw_q.y <= fmul(`PRG_FOCAL_D, cam.w_axis.y);
			dw_q.z <= fmul(`PRG_FOCAL_D, cam.w_axis.z);
		end
		if (ph0) begin
			u_q <= uv_val;
		end
		if (ph1) begin
			v_q <= uv_val;
		end
		if (ph2) begin
			// next pixel overwrites u_q on its ph0
			u_hold  <= u_q;
			v_hold  <= v_q;
			dir_q.x <= mac_out;
		end
		if (y_step) begin
			dir_q.y <= mac_out;
		end
		if (z_step) begin
			dir_q.z <= mac_out;
		end
	end

	assign dir = dir_q;
	assign eye = cam_q.eye;

endmodule

/* src/scan_timer.sv */
`timescale 1ns/10ps
`include "prg_config.svh"

module scan_timer #(
	parameter int screen_w = `PRG_SCREEN_W,
	parameter int screen_h = `PRG_SCREEN_H
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            scan_en,
	output logic            ph0,
	output logic            ph1,
	output logic            ph2,
	output prg_pkg::pixel_t pixel,
	output logic            last_pixel
);

	logic [1:0]      phase;
	prg_pkg::pixel_t pos;
	logic            at_row_end;
	logic            at_last;

	assign at_row_end = (pos.x == `PRG_X_W'(screen_w - 1));
	assign at_last    = at_row_end && (pos.y == `PRG_Y_W'(screen_h - 1));

	// one strobe per cycle, only while scanning
	assign ph0 = scan_en && (phase == 2'd0);
	assign ph1 = scan_en && (phase == 2'd1);
	assign ph2 = scan_en && (phase == 2'd2);

	assign pixel      = pos;
	assign last_pixel = scan_en && at_last;

	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			phase <= 2'd0;
			pos   <= '0;
		end else if (!scan_en) begin
			phase <= 2'd0;
			pos   <= '0;
		end else if (phase == 2'd2) begin
			phase <= 2'd0;
			// step to the next pixel at the end of the slot
			if (at_last) begin
				pos <= '0;
			end else begin
				pos.id <= pos.id + 1'b1;
				if (at_row_end) begin
					pos.x <= '0;
					pos.y <= pos.y + 1'b1;
				end else begin
					pos.x <= pos.x + 1'b1;
				end
			end
		end else begin
			phase <= phase + 2'd1;
		end
	end

endmodule

/* tb.f */
+incdir+src
src/prg_pkg.sv
src/pipe_stage.sv
src/scan_timer.sv
src/prg_fsm.sv
src/ray_dir_calc.sv
src/prg_top.sv
verif/prg_checker.sv
verif/prg_tb.sv

/* verif/prg_checker.sv */
`timescale 1ns/10ps

module prg_checker (
	input logic clk,
	input logic rst,
	input logic start,
	input logic idle,
	input logic ray_valid,
	input logic done
);

	int   fail_count = 0;
	logic started;

	// set once a frame has been accepted
	always_ff @(posedge clk, posedge rst) begin
		if (rst) begin
			started <= 1'b0;
		end else if (start && idle) begin
			started <= 1'b1;
		end
	end

	ray_spacing: assert property (@(posedge clk) disable iff (rst)
		ray_valid |=> !ray_valid [*2])
		else begin
			$error("ray_valid repeated within two cycles");
			fail_count++;
		end

	done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else begin
			$error("done longer than one cycle");
			fail_count++;
		end

	idle_no_ray: assert property (@(posedge clk) disable iff (rst) !(idle && ray_valid))
		else begin
			$error("ray_valid while idle");
			fail_count++;
		end

	quiet_before_start: assert property (@(posedge clk) disable iff (rst)
		!started |-> (!ray_valid && !done))
		else begin
			$error("output activity before the first start");
			fail_count++;
		end

endmodule

/* verif/prg_tb.sv */
`timescale 1ns/10ps
`include "prg_config.svh"

module prg_tb;

	localparam int SCR_W   = 8;
	localparam int SCR_H   = 6;
	localparam int PIXELS  = SCR_W * SCR_H;
	localparam int N_TESTS = 6;
	localparam int LIMIT   = N_TESTS * PIXELS * 3 + 200;

	logic              clk;
	logic              rst;
	logic              start;
	prg_pkg::camera_t  cam;
	logic              idle;
	logic              ray_valid;
	prg_pkg::prg_ray_t ray;
	logic              done;

	int          errors = 0;
	int          err_start;
	int          tests_failed = 0;
	string       cur_test = "reset";
	logic [31:0] rng_state = 32'h1bd0;

	// results of the last frame
	int   n_rays;
	int   n_done;
	int   n_extra;
	int   done_cyc;
	int   last_ray_cyc;
	logic idle_at_done;

	prg_top #(.screen_w(SCR_W), .screen_h(SCR_H)) DUT (
		.clk, .rst, .start, .cam, .idle, .ray_valid, .ray, .done
	);

	bind prg_top prg_checker u_checker (
		.clk, .rst, .start, .idle, .ray_valid, .done
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (LIMIT) @(posedge clk);
		$display("watchdog: test %s hung, no done after %0d cycles", cur_test, LIMIT);
		$display("Test failures found");
		$finish;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// roughly +-8.0, small enough that sums stay in range
	function automatic prg_pkg::fix_t rand_fix();
		rng_state = xorshift(rng_state);
		return {{12{rng_state[19]}}, rng_state[19:0]};
	endfunction

	function automatic prg_pkg::camera_t random_camera();
		prg_pkg::camera_t c;
		c.eye.x    = rand_fix();
		c.eye.y    = rand_fix();
		c.eye.z    = rand_fix();
		c.u_axis.x = rand_fix();
		c.u_axis.y = rand_fix();
		c.u_axis.z = rand_fix();
		c.v_axis.x = rand_fix();
		c.v_axis.y = rand_fix();
		c.v_axis.z = rand_fix();
		c.w_axis.x = rand_fix();
		c.w_axis.y = rand_fix();
		c.w_axis.z = rand_fix();
		rng_state  = xorshift(rng_state);
		c.pw       = {16'h0, rng_state[15:0]} | 32'h1000;
		return c;
	endfunction

	// Q16.16 product, middle 32 bits of the full signed product
	function automatic prg_pkg::fix_t qmul(input prg_pkg::fix_t a, input prg_pkg::fix_t b);
		logic signed [63:0] p;
		p = a * b;
		return p[47:16];
	endfunction

	function automatic prg_pkg::prg_ray_t expected_ray(input prg_pkg::camera_t c, input int k);
		prg_pkg::fix_t     u;
		prg_pkg::fix_t     v;
		prg_pkg::vector_t  dw;
		prg_pkg::prg_ray_t r;
		u    = qmul(((k % SCR_W) - SCR_W / 2) * 65536, c.pw);
		v    = qmul(((k / SCR_W) - SCR_H / 2) * 65536, c.pw);
		dw.x = qmul(`PRG_FOCAL_D, c.w_axis.x);
		dw.y = qmul(`PRG_FOCAL_D, c.w_axis.y);
		dw.z = qmul(`PRG_FOCAL_D, c.w_axis.z);
		r.pixel_id = `PRG_ID_W'(k);
		r.origin   = c.eye;
		r.dir.x    = qmul(u, c.u_axis.x) + qmul(v, c.v_axis.x) + dw.x;
		r.dir.y    = qmul(u, c.u_axis.y) + qmul(v, c.v_axis.y) + dw.y;
		r.dir.z    = qmul(u, c.u_axis.z) + qmul(v, c.v_axis.z) + dw.z;
		return r;
	endfunction

	task automatic check_ray(input prg_pkg::prg_ray_t got, input prg_pkg::prg_ray_t exp,
		input string what);
		if (got !== exp) begin
			$display("[ERROR] %0d ns: %s, got id %0d dir %h org %h, exp id %0d dir %h org %h",
				$time, what, got.pixel_id, got.dir, got.origin, exp.pixel_id, exp.dir, exp.origin);
			errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0d ns: %s, got %b expected %b", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic begin_test(input string name);
		cur_test  = name;
		err_start = errors;
	endtask

	task automatic end_test();
		if (errors == err_start) begin
			$display("test %s: ok", cur_test);
		end else begin
			$display("test %s: %0d errors", cur_test, errors - err_start);
			tests_failed++;
		end
	endtask

	// one frame from start to done, with an optional second start at cycle busy_at
	task automatic run_frame(input prg_pkg::camera_t c, input int busy_at);
		int cyc;
		n_rays  = 0;
		n_done  = 0;
		n_extra = 0;
		cyc     = 0;
		cam     = c;
		start   = 1'b1;
		while (n_done == 0) begin
			@(negedge clk);
			cyc++;
			start = (cyc == busy_at);
			if (cyc == busy_at) begin
				cam = ~c;
			end
			if (ray_valid) begin
				check_ray(ray, expected_ray(c, n_rays), "ray contents");
				check_flag(cyc == 7 + 3 * n_rays, 1'b1, "ray timing");
				last_ray_cyc = cyc;
				n_rays++;
			end
			if (done) begin
				n_done++;
				done_cyc     = cyc;
				idle_at_done = idle;
			end
		end
		// any further done or ray after the pulse is counted here
		repeat (4) begin
			@(negedge clk);
			if (done) begin
				n_done++;
			end
			if (ray_valid) begin
				n_extra++;
			end
		end
	endtask

	function automatic prg_pkg::camera_t axis_camera();
		prg_pkg::camera_t c;
		c        = '0;
		c.eye.x  = 32'sh0001_0000;
		c.eye.y  = 32'sh0002_0000;
		c.eye.z  = -32'sh0003_0000;
		c.u_axis.x = 32'sh0001_0000;
		c.v_axis.y = 32'sh0001_0000;
		c.w_axis.z = 32'sh0001_0000;
		// quarter pixel width
		c.pw     = 32'sh0000_4000;
		return c;
	endfunction

	initial begin
		prg_pkg::camera_t c;
		rst   = 1'b1;
		start = 1'b0;
		cam   = '0;
		repeat (10) @(negedge clk);
		rst = 1'b0;

		begin_test("reset_idle");
		repeat (20) begin
			@(negedge clk);
			check_flag(idle, 1'b1, "idle after reset");
			check_flag(ray_valid, 1'b0, "ray_valid after reset");
			check_flag(done, 1'b0, "done after reset");
		end
		end_test();

		begin_test("axis_frame");
		run_frame(axis_camera(), 0);
		check_flag(n_rays == PIXELS, 1'b1, "ray count");
		end_test();

		begin_test("random_frame");
		run_frame(random_camera(), 0);
		check_flag(n_rays == PIXELS, 1'b1, "ray count");
		end_test();

		begin_test("done_pulse");
		run_frame(random_camera(), 0);
		check_flag(n_done == 1, 1'b1, "single done");
		check_flag(done_cyc == last_ray_cyc + 1, 1'b1, "done right after last ray");
		check_flag(idle_at_done, 1'b1, "idle with done");
		check_flag(n_extra == 0, 1'b1, "quiet after done");
		end_test();

		begin_test("busy_start");
		run_frame(random_camera(), 40);
		check_flag(n_rays == PIXELS, 1'b1, "ray count");
		check_flag(n_done == 1, 1'b1, "single done");
		end_test();

		// previous frame used another camera, so stale values would show up here
		begin_test("new_camera");
		c = random_camera();
		run_frame(c, 0);
		check_flag(n_rays == PIXELS, 1'b1, "ray count");
		check_flag(n_extra == 0, 1'b1, "quiet after done");
		end_test();

		errors += DUT.u_checker.fail_count;
		$display("summary: %0d tests, %0d failed, %0d errors", N_TESTS, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule
